// ==== all.f ====
+incdir+design
design/dcache_pkg.sv
design/dcache_lookup_if.sv
design/dcache_fsm.sv
design/dcache_we_gen.sv
design/dcache_ctrl.sv
bench/dcache_checker.sv
bench/tb_dcache_ctrl.sv

// ==== bench/tb_dcache_ctrl.sv ====
`timescale 1ns/1ps

`include "dcache_consts.svh"

module tb_dcache_ctrl import dcache_pkg::*; ();

    typedef struct {
        logic      store;
        logic      unc;
        way_hit_t  hit;
        mem_type_t mtype;
        addr_t     addr;
        logic      way;
        int        ar_dly;
        int        beats;
        int        wf_dly;
        mem_we_t   mem_we;
        tag_we_t   tag;
    } row_t;

    row_t rows[$];

    logic      clk = 1'b0;
    logic      rstn, rvalid, wvalid, rvalid_pipe, wvalid_pipe, uncache_pipe;
    logic      way_sel, write_finish, d_arready, d_rvalid, d_rlast;
    way_hit_t  hit;
    addr_t     address;
    mem_type_t mem_type_pipe;
    mem_we_t   mem_we;
    tag_we_t   tagdv_we;
    addr_t     d_araddr;
    logic      d_arvalid, d_rready, rready, wready, lru_update;
    logic      miss_lru_update, miss_lru_way, wfsm_en, wfsm_rset;
    logic      row_start, row_end, exp_store, exp_wait, exp_way;
    mem_we_t   exp_mem_we;
    tag_we_t   exp_tagdv_we;
    addr_t     exp_araddr;
    int        exp_wfsm, exp_ar, exp_beats, exp_refill, exp_hits, exp_writes;

    always #50 clk = ~clk;

    dcache_ctrl dcache_ctrl_i (.*);

    dcache_checker chk_i (.*);

    function automatic logic sig_value(input int sel);
        case (sel)
            0: return wfsm_rset;
            1: return d_arvalid;
            2: return d_rready;
            3: return miss_lru_update;
            default: return wfsm_en;
        endcase
    endfunction

    task automatic wait_sig(input int sel, input string what);
        int   n;
        logic seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < 200) begin
            @(negedge clk);
            seen = sig_value(sel);
            n++;
        end
        if (!seen) begin
            $display("timeout waiting for %s", what);
            $display("STATUS: FAIL");
            $finish;
        end
    endtask

    task automatic add_row(input logic st, input logic unc, input way_hit_t h,
                           input mem_type_t mt, input addr_t a, input logic w,
                           input int ard, input int nb, input int wfd,
                           input mem_we_t we, input tag_we_t tg);
        rows.push_back('{st, unc, h, mt, a, w, ard, nb, wfd, we, tg});
    endtask

    task automatic run_row(input row_t r);
        logic miss;
        logic rd_req;
        miss = !r.unc && r.hit == '0;
        rd_req = miss || (r.unc && !r.store);
        @(posedge clk);
        rvalid <= !r.store;
        wvalid <= r.store;
        rvalid_pipe <= !r.store;
        wvalid_pipe <= r.store;
        uncache_pipe <= r.unc;
        hit <= r.hit;
        mem_type_pipe <= r.mtype;
        address <= r.addr;
        way_sel <= r.way;
        exp_store <= r.store;
        exp_wait <= miss || r.unc;
        exp_way <= r.way;
        exp_mem_we <= r.mem_we;
        exp_tagdv_we <= r.tag;
        exp_araddr <= {r.addr[31:4], 4'h0};
        exp_wfsm <= (miss || (r.unc && r.store)) ? 1 : 0;
        exp_ar <= rd_req ? 1 : 0;
        exp_beats <= rd_req ? r.beats : 0;
        exp_refill <= miss ? 1 : 0;
        exp_hits <= (!r.unc && r.hit != '0) ? 1 : 0;
        exp_writes <= (miss || (r.store && !r.unc && r.tag != '0)) ? 1 : 0;
        row_start <= 1'b1;
        @(posedge clk);
        rvalid <= 1'b0;
        wvalid <= 1'b0;
        row_start <= 1'b0;
        if (rd_req) begin
            wait_sig(1, "d_arvalid");
            repeat (r.ar_dly) @(posedge clk);
            @(posedge clk) d_arready <= 1'b1;
            @(posedge clk) d_arready <= 1'b0;
            wait_sig(2, "d_rready");
            for (int i = 0; i < r.beats; i++) begin
                // Stall one cycle before the second beat
                if (i == 1)
                    @(posedge clk) d_rvalid <= 1'b0;
                @(posedge clk);
                d_rvalid <= 1'b1;
                d_rlast <= (i == r.beats - 1);
            end
            @(posedge clk);
            d_rvalid <= 1'b0;
            d_rlast <= 1'b0;
        end
        if (miss)
            wait_sig(3, "refill cycle");
        if (r.unc && r.store)
            wait_sig(4, "wfsm_en pulse");
        if (miss || r.unc) begin
            repeat (r.wf_dly) @(posedge clk);
            @(posedge clk) write_finish <= 1'b1;
            wait_sig(0, "return to idle");
            @(posedge clk) write_finish <= 1'b0;
        end else begin
            wait_sig(0, "return to idle");
        end
        @(posedge clk) row_end <= 1'b1;
        @(posedge clk) row_end <= 1'b0;
    endtask

    initial begin
        {rvalid, wvalid, rvalid_pipe, wvalid_pipe, uncache_pipe, way_sel} = '0;
        {write_finish, d_arready, d_rvalid, d_rlast, row_start, row_end} = '0;
        {exp_store, exp_wait, exp_way} = '0;
        hit = '0;
        address = '0;
        mem_type_pipe = '0;
        exp_mem_we = '0;
        exp_tagdv_we = '0;
        exp_araddr = '0;
        {exp_wfsm, exp_ar, exp_beats, exp_refill, exp_hits, exp_writes} = '0;
        rstn = 1'b0;
        // store unc hit type address way ard beats wfd mem_we tagdv
        add_row(0, 0, 2'b01, 3'd0, 32'h0000_0100, 0, 0, 0, 0, 32'h0000_0000, 2'b00);
        add_row(1, 0, 2'b01, 3'd1, 32'h0000_1004, 0, 0, 0, 0, 32'h0000_00f0, 2'b01);
        add_row(1, 0, 2'b10, 3'd1, 32'h0000_200c, 0, 0, 0, 0, 32'hf000_0000, 2'b10);
        add_row(1, 0, 2'b01, 3'd1, 32'h0000_3000, 0, 0, 0, 0, 32'h0000_000f, 2'b01);
        add_row(1, 0, 2'b01, 3'd1, 32'h0000_3008, 0, 0, 0, 0, 32'h0000_0f00, 2'b01);
        add_row(1, 0, 2'b10, 3'd1, 32'h0000_3009, 0, 0, 0, 0, 32'h0f00_0000, 2'b10);
        add_row(1, 0, 2'b10, 3'd1, 32'h0000_3002, 0, 0, 0, 0, 32'h000f_0000, 2'b10);
        // Byte stores over all lanes
        add_row(1, 0, 2'b01, 3'd6, 32'h0000_4000, 0, 0, 0, 0, 32'h0000_0001, 2'b01);
        add_row(1, 0, 2'b10, 3'd6, 32'h0000_4001, 0, 0, 0, 0, 32'h0002_0000, 2'b10);
        add_row(1, 0, 2'b01, 3'd6, 32'h0000_4002, 0, 0, 0, 0, 32'h0000_0004, 2'b01);
        add_row(1, 0, 2'b10, 3'd6, 32'h0000_4003, 0, 0, 0, 0, 32'h0008_0000, 2'b10);
        add_row(1, 0, 2'b01, 3'd6, 32'h0000_4004, 0, 0, 0, 0, 32'h0000_0010, 2'b01);
        add_row(1, 0, 2'b01, 3'd6, 32'h0000_4005, 0, 0, 0, 0, 32'h0000_0020, 2'b01);
        add_row(1, 0, 2'b10, 3'd6, 32'h0000_4006, 0, 0, 0, 0, 32'h0040_0000, 2'b10);
        add_row(1, 0, 2'b01, 3'd6, 32'h0000_4007, 0, 0, 0, 0, 32'h0000_0080, 2'b01);
        add_row(1, 0, 2'b10, 3'd6, 32'h0000_4008, 0, 0, 0, 0, 32'h0100_0000, 2'b10);
        add_row(1, 0, 2'b01, 3'd6, 32'h0000_4009, 0, 0, 0, 0, 32'h0000_0200, 2'b01);
        add_row(1, 0, 2'b10, 3'd6, 32'h0000_400a, 0, 0, 0, 0, 32'h0400_0000, 2'b10);
        add_row(1, 0, 2'b01, 3'd6, 32'h0000_400b, 0, 0, 0, 0, 32'h0000_0800, 2'b01);
        add_row(1, 0, 2'b10, 3'd6, 32'h0000_400c, 0, 0, 0, 0, 32'h1000_0000, 2'b10);
        add_row(1, 0, 2'b01, 3'd6, 32'h0000_400d, 0, 0, 0, 0, 32'h0000_2000, 2'b01);
        add_row(1, 0, 2'b10, 3'd6, 32'h0000_400e, 0, 0, 0, 0, 32'h4000_0000, 2'b10);
        add_row(1, 0, 2'b10, 3'd6, 32'h0000_400f, 0, 0, 0, 0, 32'h8000_0000, 2'b10);
        // Halfword stores, even and odd offsets
        add_row(1, 0, 2'b10, 3'd7, 32'h0000_5000, 0, 0, 0, 0, 32'h0003_0000, 2'b10);
        add_row(1, 0, 2'b01, 3'd7, 32'h0000_5002, 0, 0, 0, 0, 32'h0000_000c, 2'b01);
        add_row(1, 0, 2'b10, 3'd7, 32'h0000_5004, 0, 0, 0, 0, 32'h0030_0000, 2'b10);
        add_row(1, 0, 2'b01, 3'd7, 32'h0000_5006, 0, 0, 0, 0, 32'h0000_00c0, 2'b01);
        add_row(1, 0, 2'b01, 3'd7, 32'h0000_5008, 0, 0, 0, 0, 32'h0000_0300, 2'b01);
        add_row(1, 0, 2'b10, 3'd7, 32'h0000_500a, 0, 0, 0, 0, 32'h0c00_0000, 2'b10);
        add_row(1, 0, 2'b01, 3'd7, 32'h0000_500c, 0, 0, 0, 0, 32'h0000_3000, 2'b01);
        add_row(1, 0, 2'b10, 3'd7, 32'h0000_500e, 0, 0, 0, 0, 32'hc000_0000, 2'b10);
        add_row(1, 0, 2'b01, 3'd7, 32'h0000_5003, 0, 0, 0, 0, 32'h0000_0000, 2'b01);
        add_row(1, 0, 2'b10, 3'd7, 32'h0000_500d, 0, 0, 0, 0, 32'h0000_0000, 2'b10);
        add_row(1, 0, 2'b01, 3'd2, 32'h0000_6004, 0, 0, 0, 0, 32'h0000_0000, 2'b01);
        add_row(0, 0, 2'b00, 3'd0, 32'h1234_5678, 1, 3, 4, 2, 32'hffff_0000, 2'b10);
        add_row(1, 0, 2'b00, 3'd1, 32'habcd_ef1c, 0, 0, 4, 0, 32'h0000_ffff, 2'b01);
        add_row(0, 1, 2'b00, 3'd0, 32'h8000_0013, 0, 2, 1, 1, 32'h0000_0000, 2'b00);
        add_row(1, 1, 2'b00, 3'd1, 32'h9000_0004, 0, 0, 0, 5, 32'h0000_0000, 2'b00);
        repeat (10) @(posedge clk);
        rstn <= 1'b1;
        wait_sig(0, "wfsm_rset after reset");
        foreach (rows[i])
            run_row(rows[i]);
        $display("errors: value %0d, event %0d", chk_i.value_errs, chk_i.event_errs);
        if (chk_i.value_errs == 0 && chk_i.event_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== bench/dcache_checker.sv ====
`timescale 1ns/1ps

`include "dcache_consts.svh"

module dcache_checker import dcache_pkg::*; (
    input  logic    clk,
    input  logic    rstn,
    input  logic    row_start,
    input  logic    row_end,
    input  logic    exp_store,
    input  logic    exp_wait,
    input  mem_we_t exp_mem_we,
    input  tag_we_t exp_tagdv_we,
    input  addr_t   exp_araddr,
    input  logic    exp_way,
    input  int      exp_wfsm,
    input  int      exp_ar,
    input  int      exp_beats,
    input  int      exp_refill,
    input  int      exp_hits,
    input  int      exp_writes,
    input  mem_we_t mem_we,
    input  tag_we_t tagdv_we,
    input  addr_t   d_araddr,
    input  logic    d_arvalid,
    input  logic    d_arready,
    input  logic    d_rready,
    input  logic    d_rvalid,
    input  logic    rready,
    input  logic    wready,
    input  logic    lru_update,
    input  logic    miss_lru_update,
    input  logic    miss_lru_way,
    input  logic    wfsm_en,
    input  logic    wfsm_rset,
    input  logic    write_finish
);

    int   value_errs = 0;
    int   event_errs = 0;
    int   n_wfsm, n_ar, n_beats, n_refill, n_hits, n_writes;
    logic active = 1'b0;
    logic wf_seen = 1'b0;

    task automatic report(input string msg);
        value_errs++;
        $display("mismatch at %0t: %s", $time, msg);
    endtask

    task automatic cmp_count(input string what, input int got, input int exp);
        if (got != exp) begin
            event_errs++;
            $display("mismatch at %0t: %s seen %0d times, expected %0d", $time, what, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Per-cycle checks, sampled mid-cycle
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rstn) begin
            if (row_start) begin
                n_wfsm = 0;
                n_ar = 0;
                n_beats = 0;
                n_refill = 0;
                n_hits = 0;
                n_writes = 0;
            end
            if (wfsm_rset) begin
                if (!rready || !wready || mem_we != '0 || tagdv_we != '0 || d_arvalid ||
                    d_rready || wfsm_en || lru_update || miss_lru_update)
                    report("idle outputs wrong while wfsm_rset is high");
                if (active && exp_wait && !wf_seen)
                    report("returned to idle before write_finish");
                active = 1'b0;
                wf_seen = 1'b0;
            end else begin
                active = 1'b1;
                if (write_finish)
                    wf_seen = 1'b1;
            end
            if (mem_we != '0 || tagdv_we != '0) begin
                n_writes++;
                if (mem_we != exp_mem_we || tagdv_we != exp_tagdv_we)
                    report($sformatf("mem_we %h tagdv_we %b, expected %h %b",
                                     mem_we, tagdv_we, exp_mem_we, exp_tagdv_we));
            end
            if (d_arvalid && d_araddr != exp_araddr)
                report($sformatf("d_araddr %h, expected %h", d_araddr, exp_araddr));
            if (!d_arvalid && d_araddr != '0)
                report($sformatf("d_araddr %h outside the read request", d_araddr));
            if (miss_lru_update && miss_lru_way != exp_way)
                report("miss_lru_way does not follow way_sel");
            if (lru_update) begin
                n_hits++;
                if (exp_store ? !(wready && !rready) : !(rready && !wready))
                    report("ready strobe wrong on hit");
            end
            n_wfsm   += wfsm_en;
            n_ar     += (d_arvalid && d_arready);
            n_beats  += (d_rvalid && d_rready);
            n_refill += miss_lru_update;
            if (row_end) begin
                cmp_count("wfsm_en", n_wfsm, exp_wfsm);
                cmp_count("read address handshake", n_ar, exp_ar);
                cmp_count("data beat", n_beats, exp_beats);
                cmp_count("refill cycle", n_refill, exp_refill);
                cmp_count("lru_update", n_hits, exp_hits);
                cmp_count("write cycle", n_writes, exp_writes);
            end
        end
    end

endmodule

// ==== design/dcache_ctrl.sv ====
`timescale 1ns/1ps

`include "dcache_consts.svh"

module dcache_ctrl import dcache_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      rvalid,
    input  logic      wvalid,
    input  logic      rvalid_pipe,
    input  logic      wvalid_pipe,
    input  logic      uncache_pipe,
    input  logic      way_sel,
    input  logic      write_finish,
    input  logic      d_arready,
    input  logic      d_rvalid,
    input  logic      d_rlast,
    input  way_hit_t  hit,
    input  addr_t     address,
    input  mem_type_t mem_type_pipe,
    output mem_we_t   mem_we,
    output tag_we_t   tagdv_we,
    output addr_t     d_araddr,
    output logic      d_arvalid,
    output logic      d_rready,
    output logic      rready,
    output logic      wready,
    output logic      lru_update,
    output logic      miss_lru_update,
    output logic      miss_lru_way,
    output logic      wfsm_en,
    output logic      wfsm_rset
);

    dcache_lookup_if lk_if ();

    // Lookup fields from the pipeline
    assign lk_if.hit      = hit;
    assign lk_if.address  = address;
    assign lk_if.mem_type = mem_type_pipe;
    assign lk_if.way_sel  = way_sel;

    dcache_fsm fsm_i (
        .clk             (clk),
        .rstn            (rstn),
        .rvalid          (rvalid),
        .wvalid          (wvalid),
        .rvalid_pipe     (rvalid_pipe),
        .wvalid_pipe     (wvalid_pipe),
        .uncache_pipe    (uncache_pipe),
        .way_sel         (way_sel),
        .write_finish    (write_finish),
        .d_arready       (d_arready),
        .d_rvalid        (d_rvalid),
        .d_rlast         (d_rlast),
        .lk              (lk_if.fsm),
        .d_araddr        (d_araddr),
        .d_arvalid       (d_arvalid),
        .d_rready        (d_rready),
        .rready          (rready),
        .wready          (wready),
        .lru_update      (lru_update),
        .miss_lru_update (miss_lru_update),
        .miss_lru_way    (miss_lru_way),
        .wfsm_en         (wfsm_en),
        .wfsm_rset       (wfsm_rset)
    );

    dcache_we_gen we_gen_i (
        .lk       (lk_if.we_gen),
        .mem_we   (mem_we),
        .tagdv_we (tagdv_we)
    );

endmodule

// ==== design/dcache_we_gen.sv ====
`timescale 1ns/1ps

`include "dcache_consts.svh"

module dcache_we_gen import dcache_pkg::*; (
    dcache_lookup_if.we_gen lk,
    output mem_we_t mem_we,
    output tag_we_t tagdv_we
);

    localparam int LANES = `DC_LINE_BYTES;

    offset_t           offset;
    logic [LANES-1:0]  store_lanes;
    logic [LANES-1:0]  way_lanes;
    logic              upper_way;
    logic              any_wr;

    assign offset = lk.address[`DC_OFFSET_W-1:0];
    assign any_wr = lk.store_wr || lk.refill_wr;

    ////////////////////////////////////////////////////////////
    // Byte lanes for a store
    ////////////////////////////////////////////////////////////

    always_comb begin
        store_lanes = '0;
        case (lk.mem_type)
            `DC_MT_ST_W: begin
                store_lanes = {{(LANES-4){1'b0}}, 4'hf} << {offset[3:2], 2'b00};
            end
            `DC_MT_ST_B: begin
                store_lanes = {{(LANES-1){1'b0}}, 1'b1} << offset;
            end
            `DC_MT_ST_H: begin
                // Misaligned halfword writes nothing
                if (!offset[0]) begin
                    store_lanes = {{(LANES-2){1'b0}}, 2'b11} << offset;
                end
            end
            default: begin
                store_lanes = '0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Way selection
    ////////////////////////////////////////////////////////////

    always_comb begin
        upper_way = 1'b0;
        way_lanes = '0;
        if (lk.refill_wr) begin
            upper_way = lk.way_sel;
            way_lanes = '1;
        end else if (lk.store_wr) begin
            // hit[0] set means way 0
            upper_way = !lk.hit[0];
            way_lanes = store_lanes;
        end
    end

    assign mem_we = upper_way ? {way_lanes, {LANES{1'b0}}}
                              : {{LANES{1'b0}}, way_lanes};

    assign tagdv_we = {any_wr && upper_way, any_wr && !upper_way};

endmodule

// ==== design/dcache_fsm.sv ====
`timescale 1ns/1ps

`include "dcache_consts.svh"

module dcache_fsm import dcache_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      rvalid,
    input  logic      wvalid,
    input  logic      rvalid_pipe,
    input  logic      wvalid_pipe,
    input  logic      uncache_pipe,
    input  logic      way_sel,
    input  logic      write_finish,
    input  logic      d_arready,
    input  logic      d_rvalid,
    input  logic      d_rlast,
    dcache_lookup_if.fsm lk,
    output addr_t     d_araddr,
    output logic      d_arvalid,
    output logic      d_rready,
    output logic      rready,
    output logic      wready,
    output logic      lru_update,
    output logic      miss_lru_update,
    output logic      miss_lru_way,
    output logic      wfsm_en,
    output logic      wfsm_rset
);

    dc_state_t state;
    dc_state_t state_next;

    logic      any_hit;
    logic      new_req;
    addr_t     line_addr;

    assign any_hit = |lk.hit;
    assign new_req = rvalid || wvalid;

    // Miss reads always fetch the whole line
    assign line_addr = {lk.address[`DC_ADDR_W-1:`DC_OFFSET_W], {`DC_OFFSET_W{1'b0}}};

    ////////////////////////////////////////////////////////////
    // State register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    ////////////////////////////////////////////////////////////
    // Next state and strobes
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_next      = state;
        lk.store_wr     = 1'b0;
        lk.refill_wr    = 1'b0;
        d_araddr        = '0;
        d_arvalid       = 1'b0;
        d_rready        = 1'b0;
        rready          = 1'b0;
        wready          = 1'b0;
        lru_update      = 1'b0;
        miss_lru_update = 1'b0;
        miss_lru_way    = 1'b0;
        wfsm_en         = 1'b0;
        wfsm_rset       = 1'b0;

        case (state)
            IDLE: begin
                rready    = 1'b1;
                wready    = 1'b1;
                wfsm_rset = 1'b1;
                if (new_req) begin
                    state_next = LOOKUP;
                end
            end

            LOOKUP: begin
                if (uncache_pipe) begin
                    if (rvalid_pipe) begin
                        state_next = MISS_ADDR;
                    end else begin
                        // Uncached store goes straight to the write-back side
                        state_next = WAIT_WRITE;
                        wfsm_en    = 1'b1;
                    end
                end else if (any_hit) begin
                    lru_update  = 1'b1;
                    lk.store_wr = wvalid_pipe;
                    wready      = wvalid_pipe;
                    rready      = !wvalid_pipe;
                    // Back-to-back hits stay here
                    if (new_req) begin
                        state_next = LOOKUP;
                    end else begin
                        state_next = IDLE;
                    end
                end else begin
                    // Miss, victim write-back starts in parallel
                    state_next = MISS_ADDR;
                    wfsm_en    = 1'b1;
                end
            end

            MISS_ADDR: begin
                d_arvalid = 1'b1;
                d_araddr  = line_addr;
                if (d_arready) begin
                    state_next = MISS_DATA;
                end
            end

            MISS_DATA: begin
                d_rready = 1'b1;
                if (d_rvalid && d_rlast) begin
                    if (uncache_pipe) begin
                        state_next = WAIT_WRITE;
                    end else begin
                        state_next = REFILL;
                    end
                end
            end

            REFILL: begin
                lk.refill_wr    = 1'b1;
                miss_lru_update = 1'b1;
                miss_lru_way    = way_sel;
                state_next      = WAIT_WRITE;
            end

            WAIT_WRITE: begin
                if (write_finish) begin
                    state_next = IDLE;
                end
            end

            default: begin
                state_next = IDLE;
            end
        endcase
    end

endmodule

// ==== design/dcache_lookup_if.sv ====
`timescale 1ns/1ps

`include "dcache_consts.svh"

interface dcache_lookup_if import dcache_pkg::*; ();

    // Request side, driven from the top
    way_hit_t  hit;
    addr_t     address;
    mem_type_t mem_type;
    logic      way_sel;

    // Write strobes from the FSM
    logic      store_wr;
    logic      refill_wr;

    modport fsm (
        input  hit,
        input  address,
        output store_wr,
        output refill_wr
    );

    modport we_gen (
        input  hit,
        input  address,
        input  mem_type,
        input  way_sel,
        input  store_wr,
        input  refill_wr
    );

endinterface

// ==== design/dcache_pkg.sv ====
`include "dcache_consts.svh"

package dcache_pkg;

    // Address and line offset
    typedef logic [`DC_ADDR_W-1:0]   addr_t;
    typedef logic [`DC_OFFSET_W-1:0] offset_t;

    // Per-way hit and tag write strobes
    typedef logic [`DC_WAYS-1:0]     way_hit_t;
    typedef logic [`DC_WAYS-1:0]     tag_we_t;

    // Byte enables for both ways of the data array
    typedef logic [`DC_MEMWE_W-1:0]  mem_we_t;

    typedef logic [`DC_MTYPE_W-1:0]  mem_type_t;

    // Controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS_ADDR,
        MISS_DATA,
        REFILL,
        WAIT_WRITE
    } dc_state_t;

endpackage

// ==== design/dcache_consts.svh ====
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

////////////////////////////////////////////////////////////
// Geometry
////////////////////////////////////////////////////////////

`define DC_ADDR_W      32
`define DC_WAYS        2
`define DC_LINE_BYTES  16
`define DC_OFFSET_W    4

// One enable bit per byte per way, way 0 in the low half
`define DC_MEMWE_W     32

////////////////////////////////////////////////////////////
// Store type codes
////////////////////////////////////////////////////////////

`define DC_MTYPE_W     3
`define DC_MT_ST_W     3'd1
`define DC_MT_ST_B     3'd6
`define DC_MT_ST_H     3'd7

`endif
